// ==== src/csr_access_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// Runs one CSR command through read, modify and write. Fixed latency:
// done_o one cycle after an accepted strobe. Strobes while busy are lost.
// Set and clear with a zero operand do not write.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module csr_access_unit import csr_defs_pkg::*, csr_cmd_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  logic                  cmd_valid_i,
  input  csr_op_e               cmd_op_i,
  input  logic [CSR_ADDR_W-1:0] cmd_addr_i,
  input  logic [XLEN-1:0]       cmd_operand_i,
  output logic                  busy_o,
  output logic                  done_o,
  output logic [XLEN-1:0]       rd_data_o,
  output logic                  illegal_o,
  csr_port_if.access            port_o
);

  acc_state_e            state_q;
  csr_op_e               op_q;
  logic [CSR_ADDR_W-1:0] addr_q;
  logic [XLEN-1:0]       operand_q;
  logic [XLEN-1:0]       new_val;
  logic                  writes;
  logic                  illegal;
  logic                  accept;

  assign accept = (state_q == IDLE) && cmd_valid_i;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= accept ? MODIFY : IDLE;  // MODIFY lasts one cycle
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q      <= cmd_op_i;
      addr_q    <= cmd_addr_i;
      operand_q <= cmd_operand_i;
    end
  end

  // New value from the registered old value
  always_comb begin
    new_val = port_o.rdata;
    writes  = 1'b0;
    case (op_q)
      CSRRW, CSRRWI: begin
        new_val = operand_q;
        writes  = 1'b1;
      end
      CSRRS, CSRRSI: begin
        new_val = port_o.rdata | operand_q;
        writes  = |operand_q;
      end
      CSRRC, CSRRCI: begin
        new_val = port_o.rdata & ~operand_q;
        writes  = |operand_q;
      end
      default: ;
    endcase
  end

  assign illegal = !port_o.hit || (port_o.ro && writes);

  // Incoming address in IDLE so the read lands in MODIFY
  assign port_o.addr  = (state_q == MODIFY) ? addr_q : cmd_addr_i;
  assign port_o.wdata = new_val;
  assign port_o.we    = (state_q == MODIFY) && writes && !illegal;

  assign busy_o    = (state_q == MODIFY);
  assign done_o    = (state_q == MODIFY);
  assign rd_data_o = port_o.rdata;        // Old value
  assign illegal_o = (state_q == MODIFY) && illegal;

  // One single-cycle done pulse per accepted command, and none otherwise
  a_done_after_accept: assert property (@(posedge clk_i) disable iff (!rstn_i)
    accept |=> done_o ##1 !done_o);
  a_done_has_cmd: assert property (@(posedge clk_i) disable iff (!rstn_i)
    done_o |-> $past(accept));

endmodule

// ==== src/csr_cmd_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Command encodings for the CSR access unit. Opcode values follow the
// funct3 field of the CSR instructions.
////////////////////////////////////////////////////////////////////////////

package csr_cmd_pkg;

  // Immediate forms carry an operand that is already zero-extended
  typedef enum logic [2:0] {
    CSRRW  = 3'b001,
    CSRRS  = 3'b010,
    CSRRC  = 3'b011,
    CSRRWI = 3'b101,
    CSRRSI = 3'b110,
    CSRRCI = 3'b111
  } csr_op_e;

  typedef enum logic {IDLE, MODIFY} acc_state_e;

endpackage

// ==== src/csr_defs_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Machine-mode CSR map for an RV32 core. Only the CSRs listed here are
// implemented. Any other address decodes as unknown. mtvec supports
// direct mode only.
////////////////////////////////////////////////////////////////////////////

package csr_defs_pkg;

  localparam int CSR_ADDR_W   = 12;
  localparam int XLEN         = 32;            // Fixed for RV32
  localparam int MTVEC_BASE_W = XLEN - 2;

  // CSR addresses
  localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS   = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_MISA      = 12'h301;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIE       = 12'h304;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC     = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH  = 12'h340;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC      = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE    = 12'h342;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL     = 12'h343;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIP       = 12'h344;
  localparam logic [CSR_ADDR_W-1:0] CSR_MVENDORID = 12'hF11;
  localparam logic [CSR_ADDR_W-1:0] CSR_MARCHID   = 12'hF12;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIMPID    = 12'hF13;
  localparam logic [CSR_ADDR_W-1:0] CSR_MHARTID   = 12'hF14;

  // Bit positions
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int IRQ_SW_BIT       = 3;         // Same in mie and mip
  localparam int IRQ_TIMER_BIT    = 7;
  localparam int IRQ_EXT_BIT      = 11;

  // Constant read values
  localparam logic [XLEN-1:0] MISA_VAL      = 32'h4000_0100;  // MXL=1, I
  localparam logic [XLEN-1:0] MVENDORID_VAL = '0;
  localparam logic [XLEN-1:0] MARCHID_VAL   = '0;
  localparam logic [XLEN-1:0] MIMPID_VAL    = '0;
  localparam logic [1:0]      MTVEC_MODE    = 2'b00;          // Direct

  // Reset values
  localparam logic [XLEN-1:0] MSCRATCH_RST = '0;
  localparam logic [XLEN-1:0] MEPC_RST     = '0;
  localparam logic [XLEN-1:0] MCAUSE_RST   = '0;
  localparam logic [XLEN-1:0] MTVAL_RST    = '0;

  typedef enum logic [3:0] {
    IRQ_NONE  = 4'd0,
    IRQ_SW    = 4'd3,
    IRQ_TIMER = 4'd7,
    IRQ_EXT   = 4'd11
  } irq_cause_e;

endpackage

// ==== src/csr_irq_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Interrupt status from the CSR storage to the arbiter.
// Bit order of en and pend: 0 software, 1 timer, 2 external.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface csr_irq_if ();

  logic       global_en;  // mstatus.MIE
  logic [2:0] en;         // mie.MSIE/MTIE/MEIE
  logic [2:0] pend;       // mip.MSIP/MTIP/MEIP

  // Regfile side
  modport source (output global_en, en, pend);

  // Arbiter side
  modport sink   (input  global_en, en, pend);

endinterface

// ==== src/csr_port_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Read/write port into the CSR storage. rdata is registered, one cycle
// behind addr. hit and ro are decoded from addr in the same cycle.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface csr_port_if import csr_defs_pkg::*; ();

  logic [CSR_ADDR_W-1:0] addr;
  logic [XLEN-1:0]       wdata;
  logic                  we;
  logic [XLEN-1:0]       rdata;
  logic                  hit;    // Address is implemented
  logic                  ro;     // Register is read-only

  modport access  (output addr, wdata, we, input  rdata, hit, ro);
  modport regfile (input  addr, wdata, we, output rdata, hit, ro);

endinterface

// ==== src/csr_regfile.sv ====
////////////////////////////////////////////////////////////////////////////
// Machine-mode CSR storage. Writes touch only the implemented fields.
// The caller must not write a read-only or unknown address.
// mip mirrors the interrupt lines one edge late and cannot be written.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module csr_regfile import csr_defs_pkg::*; #(
  parameter logic [XLEN-1:0]         HART_ID   = '0,
  parameter logic [MTVEC_BASE_W-1:0] TRAP_BASE = '0
) (
  input  logic              clk_i,
  input  logic              rstn_i,
  csr_port_if.regfile       port_i,
  csr_irq_if.source         irq_o,
  input  logic              sw_irq_i,
  input  logic              timer_irq_i,
  input  logic              ext_irq_i
);

  logic                    mstatus_mie_q;
  logic                    mstatus_mpie_q;
  logic [2:0]              mie_q;          // 0 sw, 1 timer, 2 ext
  logic [2:0]              mip_q;
  logic [MTVEC_BASE_W-1:0] mtvec_base_q;
  logic [XLEN-1:0]         mscratch_q;
  logic [XLEN-1:0]         mepc_q;
  logic [XLEN-1:0]         mcause_q;
  logic [XLEN-1:0]         mtval_q;
  logic [XLEN-1:0]         rdata_n;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode and read mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    port_i.hit = 1'b1;
    port_i.ro  = 1'b0;
    rdata_n    = '0;
    case (port_i.addr)
      CSR_MSTATUS: begin
        rdata_n[MSTATUS_MIE_BIT]  = mstatus_mie_q;
        rdata_n[MSTATUS_MPIE_BIT] = mstatus_mpie_q;
      end
      CSR_MIE: begin
        rdata_n[IRQ_SW_BIT]    = mie_q[0];
        rdata_n[IRQ_TIMER_BIT] = mie_q[1];
        rdata_n[IRQ_EXT_BIT]   = mie_q[2];
      end
      CSR_MIP: begin
        rdata_n[IRQ_SW_BIT]    = mip_q[0];
        rdata_n[IRQ_TIMER_BIT] = mip_q[1];
        rdata_n[IRQ_EXT_BIT]   = mip_q[2];
        port_i.ro              = 1'b1;  // Follows the lines only
      end
      CSR_MTVEC:     rdata_n = {mtvec_base_q, MTVEC_MODE};
      CSR_MSCRATCH:  rdata_n = mscratch_q;
      CSR_MEPC:      rdata_n = mepc_q;
      CSR_MCAUSE:    rdata_n = mcause_q;
      CSR_MTVAL:     rdata_n = mtval_q;
      CSR_MISA: begin
        rdata_n   = MISA_VAL;
        port_i.ro = 1'b1;
      end
      CSR_MVENDORID: begin
        rdata_n   = MVENDORID_VAL;
        port_i.ro = 1'b1;
      end
      CSR_MARCHID: begin
        rdata_n   = MARCHID_VAL;
        port_i.ro = 1'b1;
      end
      CSR_MIMPID: begin
        rdata_n   = MIMPID_VAL;
        port_i.ro = 1'b1;
      end
      CSR_MHARTID: begin
        rdata_n   = HART_ID;
        port_i.ro = 1'b1;
      end
      default: port_i.hit = 1'b0;  // Unknown address reads zero
    endcase
  end

  always_ff @(posedge clk_i) begin
    port_i.rdata <= rdata_n;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Writable fields
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
      mie_q          <= '0;
      mtvec_base_q   <= TRAP_BASE;
      mscratch_q     <= MSCRATCH_RST;
      mepc_q         <= MEPC_RST;
      mcause_q       <= MCAUSE_RST;
      mtval_q        <= MTVAL_RST;
    end else if (port_i.we) begin
      case (port_i.addr)
        CSR_MSTATUS: begin
          mstatus_mie_q  <= port_i.wdata[MSTATUS_MIE_BIT];
          mstatus_mpie_q <= port_i.wdata[MSTATUS_MPIE_BIT];
        end
        CSR_MIE: begin
          mie_q <= {port_i.wdata[IRQ_EXT_BIT], port_i.wdata[IRQ_TIMER_BIT],
                    port_i.wdata[IRQ_SW_BIT]};
        end
        CSR_MTVEC:    mtvec_base_q <= port_i.wdata[XLEN-1:2];
        CSR_MSCRATCH: mscratch_q   <= port_i.wdata;
        CSR_MEPC:     mepc_q       <= port_i.wdata;
        CSR_MCAUSE:   mcause_q     <= port_i.wdata;
        CSR_MTVAL:    mtval_q      <= port_i.wdata;
        default: ;
      endcase
    end
  end

  // Pending bits sample the lines every edge
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      mip_q <= '0;
    end else begin
      mip_q <= {ext_irq_i, timer_irq_i, sw_irq_i};
    end
  end

  assign irq_o.global_en = mstatus_mie_q;
  assign irq_o.en        = mie_q;
  assign irq_o.pend      = mip_q;

  // The access unit must filter illegal writes before they reach storage
  a_no_illegal_we: assert property (@(posedge clk_i) disable iff (!rstn_i)
    port_i.we |-> (port_i.hit && !port_i.ro));

endmodule

// ==== src/csr_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Machine-mode CSR block of an RV32 core, standalone.
// One command at a time, honoured only while busy_o is low.
// rd_data_o and illegal_o are valid while done_o is high.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module csr_top import csr_defs_pkg::*, csr_cmd_pkg::*; #(
  parameter logic [XLEN-1:0]         HART_ID   = '0,
  parameter logic [MTVEC_BASE_W-1:0] TRAP_BASE = '0
) (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  // Command
  input  logic                  cmd_valid_i,
  input  csr_op_e               cmd_op_i,
  input  logic [CSR_ADDR_W-1:0] cmd_addr_i,
  input  logic [XLEN-1:0]       cmd_operand_i,
  output logic                  busy_o,
  output logic                  done_o,
  output logic [XLEN-1:0]       rd_data_o,
  output logic                  illegal_o,
  // Interrupt lines and request
  input  logic                  sw_irq_i,
  input  logic                  timer_irq_i,
  input  logic                  ext_irq_i,
  output logic                  irq_req_o,
  output irq_cause_e            irq_cause_o
);

  csr_port_if port_if ();
  csr_irq_if  irq_if ();

  csr_access_unit access_unit_i (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_op_i      (cmd_op_i),
    .cmd_addr_i    (cmd_addr_i),
    .cmd_operand_i (cmd_operand_i),
    .busy_o        (busy_o),
    .done_o        (done_o),
    .rd_data_o     (rd_data_o),
    .illegal_o     (illegal_o),
    .port_o        (port_if.access)
  );

  csr_regfile #(
    .HART_ID   (HART_ID),
    .TRAP_BASE (TRAP_BASE)
  ) regfile_i (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .port_i      (port_if.regfile),
    .irq_o       (irq_if.source),
    .sw_irq_i    (sw_irq_i),
    .timer_irq_i (timer_irq_i),
    .ext_irq_i   (ext_irq_i)
  );

  irq_arbiter arbiter_i (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .irq_i       (irq_if.sink),
    .irq_req_o   (irq_req_o),
    .irq_cause_o (irq_cause_o)
  );

endmodule

// ==== src/irq_arbiter.sv ====
////////////////////////////////////////////////////////////////////////////
// Picks one enabled pending interrupt. Priority is external, software,
// then timer. Request and cause are registered outputs.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module irq_arbiter import csr_defs_pkg::*; (
  input  logic       clk_i,
  input  logic       rstn_i,
  csr_irq_if.sink    irq_i,
  output logic       irq_req_o,
  output irq_cause_e irq_cause_o
);

  logic [2:0] active;  // 0 sw, 1 timer, 2 ext
  irq_cause_e cause_n;

  assign active = irq_i.pend & irq_i.en & {3{irq_i.global_en}};

  always_comb begin
    if (active[2]) begin
      cause_n = IRQ_EXT;
    end else if (active[0]) begin
      cause_n = IRQ_SW;
    end else if (active[1]) begin
      cause_n = IRQ_TIMER;
    end else begin
      cause_n = IRQ_NONE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      irq_req_o   <= 1'b0;
      irq_cause_o <= IRQ_NONE;
    end else begin
      irq_req_o   <= |active;
      irq_cause_o <= cause_n;  // NONE whenever nothing is active
    end
  end

endmodule

// ==== verif/csr_cases.txt ====
# name kind | cmd: op addr operand exp_rd exp_illegal (hex)
# name kind | irq: sw timer ext exp_req exp_cause (hex)
hartid_rd    cmd 2 F14 00000000 00000005 0
misa_rd      cmd 2 301 00000000 40000100 0
vendor_rsi0  cmd 6 F11 00000000 00000000 0
hartid_wr    cmd 1 F14 12345678 00000005 1
hartid_rd2   cmd 2 F14 00000000 00000005 0
scratch_wr   cmd 1 340 A5A50F0F 00000000 0
scratch_set  cmd 2 340 0000F0F0 A5A50F0F 0
scratch_clr  cmd 3 340 A5000000 A5A5FFFF 0
scratch_rd   cmd 2 340 00000000 00A5FFFF 0
scratch_set0 cmd 2 340 00000000 00A5FFFF 0
scratch_clr0 cmd 3 340 00000000 00A5FFFF 0
misa_rsi0    cmd 6 301 00000000 40000100 0
mstatus_wr   cmd 1 300 FFFFFFFF 00000000 0
mstatus_rd   cmd 2 300 00000000 00000088 0
mie_wr       cmd 1 304 FFFFFFFF 00000000 0
mie_rd       cmd 2 304 00000000 00000888 0
mtvec_wr     cmd 1 305 FFFFFFFF 00000000 0
mtvec_rd     cmd 2 305 00000000 FFFFFFFC 0
unknown_wr   cmd 1 7C0 00000001 00000000 1
unknown_rd   cmd 2 7C0 00000000 00000000 1
irq_none     irq 0 0 0 0 0
irq_timer    irq 0 1 0 1 7
irq_all      irq 1 1 1 1 B
mip_rd       cmd 2 344 00000000 00000888 0
mip_wr       cmd 1 344 00000000 00000888 1
mstatus_clr  cmd 3 300 00000008 00000088 0
irq_masked   irq 1 1 1 0 0
mstatus_set  cmd 6 300 00000008 00000080 0
irq_sw       irq 1 1 0 1 3
irq_off      irq 0 0 0 0 0
mip_rd2      cmd 3 344 00000000 00000000 0

// ==== verif/csr_top_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for csr_top. Cases come from verif/csr_cases.txt, so the
// simulator must run from the project root. Stops at the first mismatch.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module csr_top_tb import csr_defs_pkg::*, csr_cmd_pkg::*; ();

  localparam int DONE_TIMEOUT = 10;  // Cycles
  localparam int RST_TIMEOUT  = 10;

  logic                  clk;
  logic                  rstn;
  logic                  cmd_valid;
  csr_op_e               cmd_op;
  logic [CSR_ADDR_W-1:0] cmd_addr;
  logic [XLEN-1:0]       cmd_operand;
  logic                  sw_irq;
  logic                  timer_irq;
  logic                  ext_irq;
  logic                  busy;
  logic                  done;
  logic [XLEN-1:0]       rd_data;
  logic                  illegal;
  logic                  irq_req;
  irq_cause_e            irq_cause;

  tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(2)) clk_gen_i (
    .clk_o  (clk),
    .rstn_o (rstn)
  );

  csr_top #(.HART_ID(32'd5)) csr_top_i (
    .clk_i         (clk),
    .rstn_i        (rstn),
    .cmd_valid_i   (cmd_valid),
    .cmd_op_i      (cmd_op),
    .cmd_addr_i    (cmd_addr),
    .cmd_operand_i (cmd_operand),
    .busy_o        (busy),
    .done_o        (done),
    .rd_data_o     (rd_data),
    .illegal_o     (illegal),
    .sw_irq_i      (sw_irq),
    .timer_irq_i   (timer_irq),
    .ext_irq_i     (ext_irq),
    .irq_req_o     (irq_req),
    .irq_cause_o   (irq_cause)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Checks and case runners
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_field(input logic [8*24-1:0] name, input logic [8*8-1:0] what,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act) else begin
      $display("Mismatch in %0s (%0s): expected %h, actual %h", name, what, exp, act);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic run_command(input logic [8*24-1:0] name, input logic [2:0] op,
                             input logic [CSR_ADDR_W-1:0] addr, input logic [XLEN-1:0] operand,
                             input logic [XLEN-1:0] exp_rd, input logic exp_ill);
    int cycles;
    @(posedge clk);
    #2;
    cmd_valid   = 1'b1;
    cmd_op      = csr_op_e'(op);
    cmd_addr    = addr;
    cmd_operand = operand;
    @(posedge clk);
    #2;
    cmd_valid = 1'b0;           // One-cycle strobe
    cycles    = 0;
    @(negedge clk);
    while (!done) begin
      cycles++;
      if (cycles >= DONE_TIMEOUT) begin
        $display("Timeout: done_o did not rise within %0d cycles in case %0s",
                 DONE_TIMEOUT, name);
        $display("sim failed");
        $fatal(1);
      end
      @(negedge clk);
    end
    check_field(name, "busy", 32'd1, {31'b0, busy});
    check_field(name, "rd", exp_rd, rd_data);
    check_field(name, "illegal", {31'b0, exp_ill}, {31'b0, illegal});
  endtask

  // Line change reaches irq_req two edges later, one spare edge here
  task automatic run_irq(input logic [8*24-1:0] name, input logic sw, input logic tm,
                         input logic ex, input logic exp_req, input logic [3:0] exp_cause);
    @(posedge clk);
    #2;
    sw_irq    = sw;
    timer_irq = tm;
    ext_irq   = ex;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_field(name, "irq_req", {31'b0, exp_req}, {31'b0, irq_req});
    check_field(name, "cause", {28'b0, exp_cause}, {28'b0, irq_cause});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int                fd;
    int                code;
    int                cycles;
    int                n_cases;
    logic [8*24-1:0]   tok;
    logic [8*8-1:0]    kind;
    logic [8*200-1:0]  rest;
    logic [31:0]       f0, f1, f2, f3, f4;

    cmd_valid   = 1'b0;
    cmd_op      = CSRRS;
    cmd_addr    = '0;
    cmd_operand = '0;
    sw_irq      = 1'b0;
    timer_irq   = 1'b0;
    ext_irq     = 1'b0;
    n_cases     = 0;

    cycles = 0;
    while (rstn !== 1'b1) begin
      @(posedge clk);
      cycles++;
      if (cycles > RST_TIMEOUT) begin
        $display("Timeout: reset was never released");
        $display("sim failed");
        $fatal(1);
      end
    end
    @(negedge clk);
    check_field("reset", "busy", 32'd0, {31'b0, busy});
    check_field("reset", "done", 32'd0, {31'b0, done});
    check_field("reset", "illegal", 32'd0, {31'b0, illegal});
    check_field("reset", "irq_req", 32'd0, {31'b0, irq_req});
    check_field("reset", "cause", {28'b0, IRQ_NONE}, {28'b0, irq_cause});

    fd = $fopen("verif/csr_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file verif/csr_cases.txt");
      $display("sim failed");
      $fatal(1);
    end

    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok == "#") begin
        code = $fgets(rest, fd);  // Skip comment line
      end else begin
        code = $fscanf(fd, "%s %h %h %h %h %h", kind, f0, f1, f2, f3, f4);
        if (code != 6) begin
          $display("Case line %0s has the wrong number of fields", tok);
          $display("sim failed");
          $fatal(1);
        end
        if (kind == "cmd") begin
          run_command(tok, f0[2:0], f1[CSR_ADDR_W-1:0], f2, f3, f4[0]);
        end else if (kind == "irq") begin
          run_irq(tok, f0[0], f1[0], f2[0], f3[0], f4[3:0]);
        end else begin
          $display("Case %0s has an unknown kind", tok);
          $display("sim failed");
          $fatal(1);
        end
        n_cases++;
      end
    end
    $fclose(fd);

    assert (n_cases > 0) else begin
      $display("No cases were read from the case file");
      $display("sim failed");
      $fatal(1);
    end
    $display("Ran %0d cases", n_cases);
    $display("sim passed");
    $finish;
  end

endmodule

// ==== verif/tb_clk_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset. Reset is low for RST_CYCLES rising edges
// and is released 2 ns after an edge, like the other inputs.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rstn_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rstn_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2 rstn_o = 1'b1;
  end

endmodule

// ==== verilog.f ====
src/csr_defs_pkg.sv
src/csr_cmd_pkg.sv
src/csr_port_if.sv
src/csr_irq_if.sv
src/csr_regfile.sv
src/csr_access_unit.sv
src/irq_arbiter.sv
src/csr_top.sv
verif/tb_clk_gen.sv
verif/csr_top_tb.sv
